/* dcd_config.svh */
`ifndef DCD_CONFIG_SVH
`define DCD_CONFIG_SVH

// data path width, also the pc width
`define DCD_XLEN 32

// general registers, x0 included
`define DCD_GPR_NUM 32

// dispatch fifo entries
`define DCD_QUEUE_DEPTH 2

`endif

/* dcd_ifs.sv */
`include "dcd_config.svh"

// buffered fetch entry, fetch_buffer to dispatch_msg_gen
interface fetch_entry_if;
	logic [`DCD_XLEN-1:0] pc;
	logic [31:0]            inst;
	isa_pkg::pre_dcd_t      pre_dcd;
	logic                   prdt_jump; // predicted taken
	isa_pkg::imem_err_e     imem_err;
	logic                   valid;
	logic                   ready; // entry leaves with the read response

	modport source (output pc, inst, pre_dcd, prdt_jump, imem_err, valid, input ready);
	modport sink (input pc, inst, pre_dcd, prdt_jump, imem_err, valid, output ready);
endinterface

// register read, request and registered response
interface gpr_rd_if;
	logic [4:0]             rs1_id;
	logic [4:0]             rs2_id;
	logic                   req_valid;
	logic                   req_ready;
	logic [`DCD_XLEN-1:0] rs1_v;
	logic [`DCD_XLEN-1:0] rs2_v;
	logic                   res_valid;
	logic                   res_ready;

	modport source (
		output rs1_id, rs2_id, req_valid, res_ready,
		input req_ready, rs1_v, rs2_v, res_valid
	);
	modport target (
		input rs1_id, rs2_id, req_valid, res_ready,
		output req_ready, rs1_v, rs2_v, res_valid
	);
endinterface

/* dcd_top.sv */
`include "dcd_config.svh"

module dcd_top (
	input  logic                            clk,
	input  logic                            resetn,
	input  logic                            flush_req,
	input  logic [`DCD_XLEN-1:0]          if_pc,
	input  logic [31:0]                     if_inst,
	input  logic                            if_prdt_jump,
	input  isa_pkg::imem_err_e              if_imem_err,
	input  logic                            if_valid,
	output logic                            if_ready,
	input  logic                            wb_en,
	input  logic [4:0]                      wb_rd_id,
	input  logic [`DCD_XLEN-1:0]          wb_data,
	output dispatch_pkg::dispatch_payload_u dsp_payload,
	output dispatch_pkg::inst_type_t        dsp_inst_type,
	output logic [`DCD_XLEN-1:0]          dsp_pc,
	output logic [`DCD_XLEN-1:0]          dsp_brc_pc_upd_store_din,
	output logic [4:0]                      dsp_rd_id,
	output logic                            dsp_rd_vld,
	output dispatch_pkg::dcd_err_e          dsp_err,
	output logic                            dsp_valid,
	input  logic                            dsp_ready
);
	fetch_entry_if fe_if ();
	gpr_rd_if      rd_if ();

	logic                        q_push;
	logic                        q_full;
	dispatch_pkg::dispatch_msg_t q_msg;

	fetch_buffer u_fetch_buffer (
		.clk          (clk),
		.resetn       (resetn),
		.flush_req    (flush_req),
		.if_pc        (if_pc),
		.if_inst      (if_inst),
		.if_prdt_jump (if_prdt_jump),
		.if_imem_err  (if_imem_err),
		.if_valid     (if_valid),
		.if_ready     (if_ready),
		.fe           (fe_if.source)
	);

	gpr_file u_gpr_file (
		.clk       (clk),
		.resetn    (resetn),
		.flush_req (flush_req),
		.wb_en     (wb_en),
		.wb_rd_id  (wb_rd_id),
		.wb_data   (wb_data),
		.rd        (rd_if.target)
	);

	dispatch_msg_gen u_dispatch_msg_gen (
		.clk       (clk),
		.resetn    (resetn),
		.flush_req (flush_req),
		.fe        (fe_if.sink),
		.rd        (rd_if.source),
		.q_push    (q_push),
		.q_msg     (q_msg),
		.q_full    (q_full)
	);

	dispatch_queue u_dispatch_queue (
		.clk                      (clk),
		.resetn                   (resetn),
		.flush_req                (flush_req),
		.push                     (q_push),
		.msg                      (q_msg),
		.full                     (q_full),
		.dsp_payload              (dsp_payload),
		.dsp_inst_type            (dsp_inst_type),
		.dsp_pc                   (dsp_pc),
		.dsp_brc_pc_upd_store_din (dsp_brc_pc_upd_store_din),
		.dsp_rd_id                (dsp_rd_id),
		.dsp_rd_vld               (dsp_rd_vld),
		.dsp_err                  (dsp_err),
		.dsp_valid                (dsp_valid),
		.dsp_ready                (dsp_ready)
	);

endmodule

/* dispatch_msg_gen.sv */
module dispatch_msg_gen (
	input  logic                         clk,
	input  logic                         resetn,
	input  logic                         flush_req,
	fetch_entry_if.sink                  fe,
	gpr_rd_if.source                     rd,
	output logic                         q_push,
	output dispatch_pkg::dispatch_msg_t  q_msg,
	input  logic                         q_full
);
	logic                       suppress; // read issued, response not yet taken
	logic                       take; // queue can accept this cycle
	logic                       is_ill;
	dispatch_pkg::inst_type_t   inst_type;
	dispatch_pkg::alu_msg_t     alu_msg;
	logic [2:0]                 ls_type;
	logic [31:0]                brc_pc_upd_store_din;

	assign is_ill = fe.pre_dcd.op_class == isa_pkg::OC_ILLEGAL;

	// unused source fields read x0
	assign rd.rs1_id = fe.pre_dcd.rs1_vld ? fe.inst[19:15] : 5'd0;
	assign rd.rs2_id = fe.pre_dcd.rs2_vld ? fe.inst[24:20] : 5'd0;
	assign rd.req_valid = fe.valid & ~suppress & ~flush_req;

	// entry and response leave together, straight into the queue
	assign take = ~q_full & ~flush_req;
	assign rd.res_ready = fe.valid & take;
	assign fe.ready = rd.res_valid & take;
	assign q_push = rd.res_valid & rd.res_ready;

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			suppress <= 1'b0;
		else
			suppress <= ~flush_req & (suppress | (rd.req_valid & rd.req_ready)) & ~q_push;
	end

	inst_decoder u_inst_decoder (
		.inst                 (fe.inst),
		.pc                   (fe.pc),
		.pre_dcd              (fe.pre_dcd),
		.prdt_jump            (fe.prdt_jump),
		.rs1_v                (rd.rs1_v),
		.rs2_v                (rd.rs2_v),
		.inst_type            (inst_type),
		.alu_msg              (alu_msg),
		.ls_type              (ls_type),
		.brc_pc_upd_store_din (brc_pc_upd_store_din)
	);

	always_comb
	begin
		q_msg = '0;
		case (fe.pre_dcd.op_class) // payload view
			isa_pkg::OC_LOAD, isa_pkg::OC_STORE:
			begin
				q_msg.payload.lsu.ls_type = ls_type;
				q_msg.payload.lsu.alu = alu_msg;
			end
			isa_pkg::OC_ILLEGAL: q_msg.payload.ill.inst = fe.inst; // kept for the trap
			default:
			begin
				q_msg.payload.alu.prdt_jump = fe.prdt_jump;
				q_msg.payload.alu.alu = alu_msg;
			end
		endcase
		q_msg.inst_type = is_ill ? '0 : inst_type; // an illegal word is no branch or ls
		q_msg.pc = fe.pc;
		q_msg.brc_pc_upd_store_din = brc_pc_upd_store_din;
		q_msg.rd_id = fe.inst[11:7];
		q_msg.rd_vld = fe.pre_dcd.rd_vld; // already 0 for illegal
		if (is_ill)
			q_msg.err = dispatch_pkg::DCD_ILLEGAL_INST; // wins over any fetch error
		else
			case (fe.imem_err)
				isa_pkg::IMEM_NORMAL: q_msg.err = dispatch_pkg::DCD_NORMAL;
				isa_pkg::IMEM_PC_UNALIGNED: q_msg.err = dispatch_pkg::DCD_PC_UNALIGNED;
				isa_pkg::IMEM_BUS_ERR, isa_pkg::IMEM_TIMEOUT:
					q_msg.err = dispatch_pkg::DCD_BUS_FAIL;
				default: q_msg.err = dispatch_pkg::DCD_BUS_FAIL;
			endcase
	end

endmodule

/* dispatch_pkg.sv */
`include "dcd_config.svh"

package dispatch_pkg;

	typedef enum logic [1:0] {
		DCD_NORMAL       = 2'b00,
		DCD_ILLEGAL_INST = 2'b01,
		DCD_PC_UNALIGNED = 2'b10,
		DCD_BUS_FAIL     = 2'b11 // bus error or timeout
	} dcd_err_e;

	typedef struct packed {
		logic is_b;
		logic is_load;
		logic is_store;
	} inst_type_t;

	// alu functions, the compare ones serve the branches
	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL,
		ALU_SRA, ALU_OR, ALU_AND, ALU_EQ, ALU_NE, ALU_GE, ALU_GEU
	} alu_op_e;

	typedef struct packed {
		alu_op_e                alu_op;
		logic [`DCD_XLEN-1:0] op1;
		logic [`DCD_XLEN-1:0] op2;
	} alu_msg_t;

	// one payload word, read three ways depending on the class
	typedef union packed {
		struct packed {
			logic [2:0] ls_type; // funct3 of the load or store
			alu_msg_t   alu; // address computation
		} lsu;
		struct packed {
			logic [1:0] pad;
			logic       prdt_jump;
			alu_msg_t   alu;
		} alu;
		struct packed {
			logic [2*`DCD_XLEN-26:0] pad;
			logic [31:0]              inst; // raw word of the illegal instruction
		} ill;
	} dispatch_payload_u;

	typedef struct packed {
		dispatch_payload_u      payload;
		inst_type_t             inst_type;
		logic [`DCD_XLEN-1:0] pc;
		logic [`DCD_XLEN-1:0] brc_pc_upd_store_din; // corrected pc or store data
		logic [4:0]             rd_id;
		logic                   rd_vld;
		dcd_err_e               err;
	} dispatch_msg_t;

endpackage

/* dispatch_queue.sv */
`include "dcd_config.svh"

module dispatch_queue (
	input  logic                            clk,
	input  logic                            resetn,
	input  logic                            flush_req,
	input  logic                            push,
	input  dispatch_pkg::dispatch_msg_t     msg,
	output logic                            full,
	output dispatch_pkg::dispatch_payload_u dsp_payload,
	output dispatch_pkg::inst_type_t        dsp_inst_type,
	output logic [`DCD_XLEN-1:0]          dsp_pc,
	output logic [`DCD_XLEN-1:0]          dsp_brc_pc_upd_store_din,
	output logic [4:0]                      dsp_rd_id,
	output logic                            dsp_rd_vld,
	output dispatch_pkg::dcd_err_e          dsp_err,
	output logic                            dsp_valid,
	input  logic                            dsp_ready
);
	localparam int PTR_W = (`DCD_QUEUE_DEPTH > 1) ? $clog2(`DCD_QUEUE_DEPTH) : 1;
	localparam int CNT_W = $clog2(`DCD_QUEUE_DEPTH + 1);

	dispatch_pkg::dispatch_msg_t mem [`DCD_QUEUE_DEPTH];
	dispatch_pkg::dispatch_msg_t head;
	logic [PTR_W-1:0]            wr_ptr;
	logic [PTR_W-1:0]            rd_ptr;
	logic [CNT_W-1:0]            count;
	logic                        pop;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(`DCD_QUEUE_DEPTH - 1)) ? '0 : p + 1'b1; // any depth
	endfunction

	assign full = count == CNT_W'(`DCD_QUEUE_DEPTH);
	assign dsp_valid = (count != '0) & ~flush_req; // low in the flush cycle too
	assign pop = dsp_valid & dsp_ready;

	assign head = mem[rd_ptr];
	assign dsp_payload = head.payload;
	assign dsp_inst_type = head.inst_type;
	assign dsp_pc = head.pc;
	assign dsp_brc_pc_upd_store_din = head.brc_pc_upd_store_din;
	assign dsp_rd_id = head.rd_id;
	assign dsp_rd_vld = head.rd_vld;
	assign dsp_err = head.err;

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= msg;
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else if (flush_req)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0; // all entries gone
		end
		else
		begin
			if (push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // none, or both at once
			endcase
		end
	end

endmodule

/* fetch_buffer.sv */
`include "dcd_config.svh"

module fetch_buffer (
	input  logic                   clk,
	input  logic                   resetn,
	input  logic                   flush_req,
	input  logic [`DCD_XLEN-1:0] if_pc,
	input  logic [31:0]            if_inst,
	input  logic                   if_prdt_jump,
	input  isa_pkg::imem_err_e     if_imem_err,
	input  logic                   if_valid,
	output logic                   if_ready,
	fetch_entry_if.source          fe
);
	logic               init_done; // keeps if_ready low through reset
	logic               load;
	logic [2:0]         funct3;
	logic [6:0]         funct7;
	logic               sub_sra; // funct3 of add/sub or srl/sra
	isa_pkg::op_class_e cls;
	isa_pkg::pre_dcd_t  pre;

	assign funct3 = if_inst[14:12];
	assign funct7 = if_inst[31:25];
	assign sub_sra = (funct3 == 3'b000) || (funct3 == 3'b101);

	// empty, or the held entry leaves this cycle
	assign if_ready = init_done & ~flush_req & (~fe.valid | fe.ready);
	assign load = if_valid & if_ready;

	// opcode class, bad funct fields fall to illegal
	always_comb
	begin
		cls = isa_pkg::OC_ILLEGAL;
		case (if_inst[6:0])
			isa_pkg::OPC_OP:
				if (funct7 == 7'b0000000 || (funct7 == 7'b0100000 && sub_sra))
					cls = isa_pkg::OC_ALU_REG; // funct7 0000001 is mul/div, not here
			isa_pkg::OPC_OP_IMM:
				if (funct3 == 3'b001 && funct7 == 7'b0000000)
					cls = isa_pkg::OC_ALU_IMM; // slli
				else if (funct3 == 3'b101 && funct7[6] == 1'b0 && funct7[4:0] == 5'd0)
					cls = isa_pkg::OC_ALU_IMM; // srli / srai
				else if (funct3[1:0] != 2'b01)
					cls = isa_pkg::OC_ALU_IMM;
			isa_pkg::OPC_LOAD:
				if (funct3 != 3'b011 && funct3[2:1] != 2'b11)
					cls = isa_pkg::OC_LOAD; // lb lh lw lbu lhu
			isa_pkg::OPC_STORE:
				if (funct3[2] == 1'b0 && funct3 != 3'b011)
					cls = isa_pkg::OC_STORE;
			isa_pkg::OPC_BRANCH:
				if (funct3[2:1] != 2'b01)
					cls = isa_pkg::OC_BRANCH;
			isa_pkg::OPC_JAL: cls = isa_pkg::OC_JAL;
			isa_pkg::OPC_LUI: cls = isa_pkg::OC_LUI;
			default: cls = isa_pkg::OC_ILLEGAL; // unknown opcode, 16-bit forms too
		endcase
	end

	// illegal is in none of the lists, so its flags stay 0
	assign pre.op_class = cls;
	assign pre.rs1_vld = cls inside {isa_pkg::OC_ALU_REG, isa_pkg::OC_ALU_IMM,
		isa_pkg::OC_LOAD, isa_pkg::OC_STORE, isa_pkg::OC_BRANCH};
	assign pre.rs2_vld = cls inside {isa_pkg::OC_ALU_REG, isa_pkg::OC_STORE,
		isa_pkg::OC_BRANCH};
	assign pre.rd_vld = cls inside {isa_pkg::OC_ALU_REG, isa_pkg::OC_ALU_IMM,
		isa_pkg::OC_LOAD, isa_pkg::OC_JAL, isa_pkg::OC_LUI};

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			init_done <= 1'b0;
			fe.valid <= 1'b0;
		end
		else
		begin
			init_done <= 1'b1;
			if (flush_req)
				fe.valid <= 1'b0; // drop the held entry
			else if (load)
				fe.valid <= 1'b1;
			else if (fe.ready)
				fe.valid <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (load)
		begin
			fe.pc <= if_pc;
			fe.inst <= if_inst;
			fe.pre_dcd <= pre;
			fe.prdt_jump <= if_prdt_jump;
			fe.imem_err <= if_imem_err;
		end
	end

endmodule

/* files.f */
+incdir+.
isa_pkg.sv
dispatch_pkg.sv
dcd_ifs.sv
fetch_buffer.sv
gpr_file.sv
inst_decoder.sv
dispatch_msg_gen.sv
dispatch_queue.sv
dcd_top.sv
tb_dcd_top.sv

/* gpr_file.sv */
`include "dcd_config.svh"

module gpr_file (
	input  logic                   clk,
	input  logic                   resetn,
	input  logic                   flush_req,
	input  logic                   wb_en,
	input  logic [4:0]             wb_rd_id,
	input  logic [`DCD_XLEN-1:0] wb_data,
	gpr_rd_if.target               rd
);
	logic [`DCD_XLEN-1:0] regs [`DCD_GPR_NUM];
	logic                   req_hs;

	assign rd.req_ready = ~rd.res_valid; // one response in flight at most
	assign req_hs = rd.req_valid & rd.req_ready;

	// write-back port, x0 stays unwritten
	always_ff @(posedge clk)
	begin
		if (wb_en && wb_rd_id != 5'd0)
			regs[wb_rd_id] <= wb_data;
	end

	// response data sampled at the request handshake, x0 reads 0
	always_ff @(posedge clk)
	begin
		if (req_hs)
		begin
			rd.rs1_v <= (rd.rs1_id == 5'd0) ? '0 : regs[rd.rs1_id];
			rd.rs2_v <= (rd.rs2_id == 5'd0) ? '0 : regs[rd.rs2_id];
		end
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			rd.res_valid <= 1'b0;
		else if (flush_req)
			rd.res_valid <= 1'b0; // pending response dropped
		else if (req_hs)
			rd.res_valid <= 1'b1;
		else if (rd.res_ready)
			rd.res_valid <= 1'b0; // held until taken
	end

endmodule

/* inst_decoder.sv */
`include "dcd_config.svh"

module inst_decoder (
	input  logic [31:0]                inst,
	input  logic [`DCD_XLEN-1:0]     pc,
	input  isa_pkg::pre_dcd_t          pre_dcd,
	input  logic                       prdt_jump,
	input  logic [`DCD_XLEN-1:0]     rs1_v,
	input  logic [`DCD_XLEN-1:0]     rs2_v,
	output dispatch_pkg::inst_type_t   inst_type,
	output dispatch_pkg::alu_msg_t     alu_msg,
	output logic [2:0]                 ls_type,
	output logic [`DCD_XLEN-1:0]     brc_pc_upd_store_din
);
	logic [2:0]             funct3;
	logic                   sub_sel; // only register form has sub
	logic [`DCD_XLEN-1:0] imm_i;
	logic [`DCD_XLEN-1:0] imm_s;
	logic [`DCD_XLEN-1:0] imm_b;
	logic [`DCD_XLEN-1:0] imm_u;
	logic [`DCD_XLEN-1:0] imm_j;
	logic [`DCD_XLEN-1:0] shamt;
	logic [`DCD_XLEN-1:0] pc_plus4;
	dispatch_pkg::alu_op_e  arith_op;
	dispatch_pkg::alu_op_e  br_op;

	assign funct3 = inst[14:12];
	assign sub_sel = inst[30] & (pre_dcd.op_class == isa_pkg::OC_ALU_REG);
	assign imm_i = {{(`DCD_XLEN-12){inst[31]}}, inst[31:20]};
	assign imm_s = {{(`DCD_XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{(`DCD_XLEN-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{(`DCD_XLEN-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
	assign shamt = {{(`DCD_XLEN-5){1'b0}}, inst[24:20]}; // drops the srai marker bit
	assign pc_plus4 = pc + `DCD_XLEN'(4);
	assign ls_type = funct3;

	// type flags straight from the opcode, legality is checked later
	assign inst_type.is_b = inst[6:0] == isa_pkg::OPC_BRANCH;
	assign inst_type.is_load = inst[6:0] == isa_pkg::OPC_LOAD;
	assign inst_type.is_store = inst[6:0] == isa_pkg::OPC_STORE;

	always_comb
	begin
		case (funct3) // shared by op and op-imm
			3'b000: arith_op = sub_sel ? dispatch_pkg::ALU_SUB : dispatch_pkg::ALU_ADD;
			3'b001: arith_op = dispatch_pkg::ALU_SLL;
			3'b010: arith_op = dispatch_pkg::ALU_SLT;
			3'b011: arith_op = dispatch_pkg::ALU_SLTU;
			3'b100: arith_op = dispatch_pkg::ALU_XOR;
			3'b101: arith_op = inst[30] ? dispatch_pkg::ALU_SRA : dispatch_pkg::ALU_SRL;
			3'b110: arith_op = dispatch_pkg::ALU_OR;
			default: arith_op = dispatch_pkg::ALU_AND;
		endcase
		case (funct3) // branch compare
			3'b000: br_op = dispatch_pkg::ALU_EQ;
			3'b001: br_op = dispatch_pkg::ALU_NE;
			3'b100: br_op = dispatch_pkg::ALU_SLT;
			3'b101: br_op = dispatch_pkg::ALU_GE;
			3'b110: br_op = dispatch_pkg::ALU_SLTU;
			default: br_op = dispatch_pkg::ALU_GEU;
		endcase
	end

	// operand select, load is rs1 + imm_i as the default
	always_comb
	begin
		alu_msg.alu_op = dispatch_pkg::ALU_ADD;
		alu_msg.op1 = rs1_v;
		alu_msg.op2 = imm_i;
		case (pre_dcd.op_class)
			isa_pkg::OC_ALU_REG:
			begin
				alu_msg.alu_op = arith_op;
				alu_msg.op2 = rs2_v;
			end
			isa_pkg::OC_ALU_IMM:
			begin
				alu_msg.alu_op = arith_op;
				if (funct3[1:0] == 2'b01)
					alu_msg.op2 = shamt;
			end
			isa_pkg::OC_STORE: alu_msg.op2 = imm_s; // store address
			isa_pkg::OC_BRANCH:
			begin
				alu_msg.alu_op = br_op;
				alu_msg.op2 = rs2_v;
			end
			isa_pkg::OC_JAL:
			begin
				alu_msg.op1 = pc; // link value pc + 4
				alu_msg.op2 = `DCD_XLEN'(4);
			end
			isa_pkg::OC_LUI:
			begin
				alu_msg.op1 = '0;
				alu_msg.op2 = imm_u;
			end
			isa_pkg::OC_ILLEGAL:
			begin
				alu_msg.op1 = '0; // nop
				alu_msg.op2 = '0;
			end
			default: ;
		endcase
	end

	// pc to continue with when the prediction was wrong, store data for stores
	always_comb
	begin
		case (pre_dcd.op_class)
			isa_pkg::OC_STORE: brc_pc_upd_store_din = rs2_v;
			isa_pkg::OC_BRANCH: brc_pc_upd_store_din = prdt_jump ? pc_plus4 : pc + imm_b;
			isa_pkg::OC_JAL: brc_pc_upd_store_din = pc + imm_j;
			default: brc_pc_upd_store_din = pc_plus4;
		endcase
	end

endmodule

/* isa_pkg.sv */
package isa_pkg;

	// fetch side error code, as reported by the instruction memory
	typedef enum logic [1:0] {
		IMEM_NORMAL       = 2'b00,
		IMEM_PC_UNALIGNED = 2'b01,
		IMEM_BUS_ERR      = 2'b10,
		IMEM_TIMEOUT      = 2'b11 // no response in time
	} imem_err_e;

	// major opcodes of the supported 32-bit instructions
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_BRANCH = 7'b1100011,
		OPC_JAL    = 7'b1101111,
		OPC_LUI    = 7'b0110111
	} opcode_e;

	// instruction class found at pre-decode
	typedef enum logic [2:0] {
		OC_ALU_REG = 3'd0,
		OC_ALU_IMM = 3'd1,
		OC_LOAD    = 3'd2,
		OC_STORE   = 3'd3,
		OC_BRANCH  = 3'd4,
		OC_JAL     = 3'd5,
		OC_LUI     = 3'd6,
		OC_ILLEGAL = 3'd7 // dispatched as nop
	} op_class_e;

	// pre-decode flags, stored with the fetched word
	typedef struct packed {
		op_class_e op_class;
		logic      rs1_vld; // reads rs1
		logic      rs2_vld; // reads rs2
		logic      rd_vld; // writes rd
	} pre_dcd_t;

endpackage

/* run.sh */
#!/bin/sh
# build and run the dcd_top testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f files.f --top-module tb_dcd_top -o sim_dcd

./obj_dir/sim_dcd > sim.log 2>&1 || true
cat sim.log

if grep -q "Testbench failed" sim.log; then
	exit 1
fi
if ! grep -q "Testbench passed" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
exit 0

/* tb_dcd_top.sv */
`include "dcd_config.svh"

module tb_dcd_top;
	logic                            clk;
	logic                            resetn;
	logic                            flush_req;
	logic [`DCD_XLEN-1:0]          if_pc;
	logic [31:0]                     if_inst;
	logic                            if_prdt_jump;
	isa_pkg::imem_err_e              if_imem_err;
	logic                            if_valid;
	logic                            if_ready;
	logic                            wb_en;
	logic [4:0]                      wb_rd_id;
	logic [`DCD_XLEN-1:0]          wb_data;
	dispatch_pkg::dispatch_payload_u dsp_payload;
	dispatch_pkg::inst_type_t        dsp_inst_type;
	logic [`DCD_XLEN-1:0]          dsp_pc;
	logic [`DCD_XLEN-1:0]          dsp_brc_pc_upd_store_din;
	logic [4:0]                      dsp_rd_id;
	logic                            dsp_rd_vld;
	dispatch_pkg::dcd_err_e          dsp_err;
	logic                            dsp_valid;
	logic                            dsp_ready;

	logic [31:0]                 ref_regs [32]; // register model with x0 kept 0
	dispatch_pkg::dispatch_msg_t exp_q [$]; // expected messages in fetch order
	logic [15:0]                 lfsr_state;
	int                          errors;
	int                          checks;

	dcd_top u_dcd_top (.*);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// galois lfsr stepped once per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic        b;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			b = lfsr_state[0];
			lfsr_state = lfsr_state >> 1;
			if (b)
				lfsr_state = lfsr_state ^ 16'hB400;
			r = {r[30:0], b};
		end
		return r;
	endfunction

	// instruction encoders
	function automatic logic [31:0] enc_r(input logic [4:0] rd, rs1, rs2);
		return {7'b0, rs2, rs1, 3'b000, rd, 7'b0110011}; // add
	endfunction

	function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [4:0] rd, rs1,
		input logic [11:0] imm);
		logic [2:0] f3;
		f3 = (opc == 7'b0000011) ? 3'b010 : 3'b000; // lw or addi
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_s(input logic [4:0] rs1, rs2, input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011}; // sw
	endfunction

	function automatic logic [31:0] enc_b(input logic [4:0] rs1, rs2, input logic [12:0] imm);
		return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011}; // beq
	endfunction

	function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	function automatic logic [31:0] enc_u(input logic [4:0] rd, input logic [19:0] imm);
		return {imm, rd, 7'b0110111}; // lui
	endfunction

	// reference message from the decode rules
	function automatic dispatch_pkg::dispatch_msg_t expect_msg(input logic [31:0] inst,
		input logic [31:0] pc, input logic pj, input isa_pkg::imem_err_e ierr);
		dispatch_pkg::dispatch_msg_t m;
		logic [31:0]                 v1;
		logic [31:0]                 v2;
		logic [31:0]                 imm_i;
		logic [31:0]                 imm_s;
		logic [31:0]                 imm_b;
		logic [31:0]                 imm_j;
		logic                        bad_f3;
		v1 = ref_regs[inst[19:15]];
		v2 = ref_regs[inst[24:20]];
		imm_i = 32'($signed(inst[31:20]));
		imm_s = 32'($signed({inst[31:25], inst[11:7]}));
		imm_b = 32'($signed({inst[31], inst[7], inst[30:25], inst[11:8], 1'b0}));
		imm_j = 32'($signed({inst[31], inst[19:12], inst[20], inst[30:21], 1'b0}));
		// funct3 codes that rv32i leaves unused
		bad_f3 = (inst[6:0] == 7'b1100011 && inst[14:12] inside {3'b010, 3'b011}) ||
			(inst[6:0] == 7'b0000011 && inst[14:12] inside {3'b011, 3'b110, 3'b111}) ||
			(inst[6:0] == 7'b0100011 && inst[14:12] > 3'b010);
		m = '0;
		m.pc = pc;
		m.rd_id = inst[11:7];
		m.brc_pc_upd_store_din = pc + 32'd4;
		case (ierr)
			isa_pkg::IMEM_NORMAL: m.err = dispatch_pkg::DCD_NORMAL;
			isa_pkg::IMEM_PC_UNALIGNED: m.err = dispatch_pkg::DCD_PC_UNALIGNED;
			default: m.err = dispatch_pkg::DCD_BUS_FAIL; // bus error and timeout alike
		endcase
		m.payload.alu.prdt_jump = pj;
		m.payload.alu.alu.alu_op = dispatch_pkg::ALU_ADD;
		case (bad_f3 ? 7'b0000000 : inst[6:0])
			7'b0110011:
			begin
				m.payload.alu.alu.op1 = v1;
				m.payload.alu.alu.op2 = v2;
				m.rd_vld = 1'b1;
			end
			7'b0010011:
			begin
				m.payload.alu.alu.op1 = v1;
				m.payload.alu.alu.op2 = imm_i;
				m.rd_vld = 1'b1;
			end
			7'b0000011, 7'b0100011:
			begin
				m.payload = '0;
				m.payload.lsu.ls_type = inst[14:12];
				m.payload.lsu.alu.alu_op = dispatch_pkg::ALU_ADD; // address add
				m.payload.lsu.alu.op1 = v1;
				m.payload.lsu.alu.op2 = inst[5] ? imm_s : imm_i;
				m.inst_type.is_store = inst[5];
				m.inst_type.is_load = ~inst[5];
				m.rd_vld = ~inst[5];
				if (inst[5])
					m.brc_pc_upd_store_din = v2; // store data
			end
			7'b1100011:
			begin
				m.payload.alu.alu.alu_op = dispatch_pkg::ALU_EQ;
				m.payload.alu.alu.op1 = v1;
				m.payload.alu.alu.op2 = v2;
				m.inst_type.is_b = 1'b1;
				m.brc_pc_upd_store_din = pj ? pc + 32'd4 : pc + imm_b;
			end
			7'b1101111:
			begin
				m.payload.alu.alu.op1 = pc;
				m.payload.alu.alu.op2 = 32'd4;
				m.rd_vld = 1'b1;
				m.brc_pc_upd_store_din = pc + imm_j;
			end
			7'b0110111:
			begin
				m.payload.alu.alu.op2 = {inst[31:12], 12'b0};
				m.rd_vld = 1'b1;
			end
			default:
			begin
				m.payload = '0;
				m.payload.ill.inst = inst; // raw word of the nop
				m.err = dispatch_pkg::DCD_ILLEGAL_INST; // beats any fetch error
			end
		endcase
		return m;
	endfunction

	task automatic check_val(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			$display("[FAIL] %0t %s got %h exp %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic write_reg(input logic [4:0] id, input logic [31:0] data);
		@(posedge clk);
		wb_en <= 1'b1;
		wb_rd_id <= id;
		wb_data <= data;
		@(posedge clk);
		wb_en <= 1'b0;
		if (id != 5'd0)
			ref_regs[id] = data;
	endtask

	// one fetch handshake with the expected message queued first
	task automatic send(input logic [31:0] inst, input logic [31:0] pc, input logic pj,
		input isa_pkg::imem_err_e ierr);
		int wait_cnt;
		exp_q.push_back(expect_msg(inst, pc, pj, ierr));
		@(posedge clk);
		if_valid <= 1'b1;
		if_inst <= inst;
		if_pc <= pc;
		if_prdt_jump <= pj;
		if_imem_err <= ierr;
		wait_cnt = 0;
		@(negedge clk);
		while (!if_ready && wait_cnt < 200)
		begin
			wait_cnt++;
			@(negedge clk);
		end
		if (!if_ready)
		begin
			$display("timeout: if_ready never rose for pc %h", pc);
			errors++;
		end
		@(posedge clk);
		if_valid <= 1'b0;
	endtask

	// takes n messages with random dsp_ready if rnd
	task automatic recv(input int n, input logic rnd);
		dispatch_pkg::dispatch_msg_t e;
		int                          got;
		int                          idle;
		got = 0;
		idle = 0;
		while (got < n && idle < 200)
		begin
			@(posedge clk);
			dsp_ready <= rnd ? rand_bits(1) : 1'b1;
			@(negedge clk);
			if (dsp_valid && dsp_ready)
			begin
				e = exp_q.pop_front();
				check_val("dsp_payload", dsp_payload, e.payload);
				check_val("dsp_inst_type", dsp_inst_type, e.inst_type);
				check_val("dsp_pc", dsp_pc, e.pc);
				check_val("dsp_brc_pc_upd_store_din", dsp_brc_pc_upd_store_din,
					e.brc_pc_upd_store_din);
				check_val("dsp_rd_id", dsp_rd_id, e.rd_id);
				check_val("dsp_rd_vld", dsp_rd_vld, e.rd_vld);
				check_val("dsp_err", dsp_err, e.err);
				got++;
				idle = 0;
			end
			else
				idle++;
		end
		if (got < n)
		begin
			$display("timeout: only %0d of %0d messages came out", got, n);
			errors++;
		end
		@(posedge clk);
		dsp_ready <= 1'b1;
	endtask

	task automatic report(input string name, input int err_before);
		$display("%s done, %0d errors", name, errors - err_before);
	endtask

	task automatic test_alu();
		int e0;
		e0 = errors;
		write_reg(5'd1, 32'h1234_5678);
		write_reg(5'd2, 32'h0F0F_0001);
		fork
			begin
				send(enc_r(5'd3, 5'd1, 5'd2), 32'h100, 1'b0, isa_pkg::IMEM_NORMAL);
				send(enc_i(7'b0010011, 5'd4, 5'd1, 12'hFFB), 32'h104, 1'b0,
					isa_pkg::IMEM_NORMAL); // addi -5
			end
			recv(2, 1'b0);
		join
		report("alu", e0);
	endtask

	task automatic test_lsu();
		int e0;
		e0 = errors;
		write_reg(5'd5, 32'h0000_1000);
		write_reg(5'd6, 32'hCAFE_F00D);
		write_reg(5'd0, 32'hFFFF_FFFF); // ignored by x0
		fork
			begin
				send(enc_i(7'b0000011, 5'd7, 5'd5, 12'd16), 32'h200, 1'b0, isa_pkg::IMEM_NORMAL);
				send(enc_s(5'd5, 5'd6, 12'hFF8), 32'h204, 1'b0, isa_pkg::IMEM_NORMAL);
				send(enc_s(5'd5, 5'd0, 12'd4), 32'h208, 1'b0, isa_pkg::IMEM_NORMAL);
				send(enc_i(7'b0000011, 5'd8, 5'd0, 12'd32), 32'h20C, 1'b0, isa_pkg::IMEM_NORMAL);
			end
			recv(4, 1'b0);
		join
		report("load/store", e0);
	endtask

	task automatic test_branch();
		int e0;
		e0 = errors;
		fork
			begin
				send(enc_b(5'd1, 5'd2, 13'd16), 32'h300, 1'b1, isa_pkg::IMEM_NORMAL);
				send(enc_b(5'd1, 5'd2, 13'd16), 32'h304, 1'b0, isa_pkg::IMEM_NORMAL);
				send(enc_b(5'd1, 5'd1, 13'h1FE0), 32'h308, 1'b0, isa_pkg::IMEM_NORMAL); // -32
				send(enc_j(5'd1, 21'd2048), 32'h30C, 1'b0, isa_pkg::IMEM_NORMAL);
				send(enc_j(5'd9, 21'h1FFFF0), 32'h310, 1'b1, isa_pkg::IMEM_NORMAL); // -16
			end
			recv(5, 1'b0);
		join
		report("branch/jal", e0);
	endtask

	task automatic test_errors();
		int e0;
		e0 = errors;
		fork
			begin
				send(32'hDEAD_BE8B, 32'h400, 1'b0, isa_pkg::IMEM_NORMAL); // custom-0 opcode
				send(enc_r(5'd3, 5'd1, 5'd2), 32'h402, 1'b0, isa_pkg::IMEM_PC_UNALIGNED);
				send(enc_r(5'd3, 5'd1, 5'd2), 32'h408, 1'b0, isa_pkg::IMEM_BUS_ERR);
				send(enc_u(5'd10, 20'hABCDE), 32'h40C, 1'b0, isa_pkg::IMEM_TIMEOUT);
				send(32'h0000_007F, 32'h410, 1'b1, isa_pkg::IMEM_BUS_ERR); // illegal wins
				send(32'h0020_A063, 32'h414, 1'b1, isa_pkg::IMEM_NORMAL); // branch with funct3 010
			end
			recv(6, 1'b0);
		join
		report("illegal/errors", e0);
	endtask

	task automatic test_random();
		logic [31:0]        insts [20];
		logic               pjs [20];
		isa_pkg::imem_err_e errs [20];
		logic [2:0]         kind;
		int                 e0;
		e0 = errors;
		for (int i = 0; i < 20; i++)
		begin
			kind = rand_bits(3);
			case (kind)
				3'd0: insts[i] = enc_r(rand_bits(5), rand_bits(5), rand_bits(5));
				3'd1: insts[i] = enc_i(7'b0010011, rand_bits(5), rand_bits(5), rand_bits(12));
				3'd2: insts[i] = enc_i(7'b0000011, rand_bits(5), rand_bits(5), rand_bits(12));
				3'd3: insts[i] = enc_s(rand_bits(5), rand_bits(5), rand_bits(12));
				3'd4: insts[i] = enc_b(rand_bits(5), rand_bits(5), {12'(rand_bits(12)), 1'b0});
				3'd5: insts[i] = enc_j(rand_bits(5), {20'(rand_bits(20)), 1'b0});
				3'd6: insts[i] = enc_u(rand_bits(5), rand_bits(20));
				default: insts[i] = {25'(rand_bits(25)), 7'b0001011}; // illegal
			endcase
			pjs[i] = rand_bits(1);
			errs[i] = isa_pkg::imem_err_e'(rand_bits(2));
		end
		fork
			for (int i = 0; i < 20; i++)
				send(insts[i], 32'h1000 + 32'(i * 4), pjs[i], errs[i]);
			recv(20, 1'b1);
		join
		report("random", e0);
	endtask

	task automatic test_flush();
		int e0;
		e0 = errors;
		@(posedge clk);
		dsp_ready <= 1'b0; // stall so entries pile up
		send(enc_r(5'd3, 5'd1, 5'd2), 32'h500, 1'b0, isa_pkg::IMEM_NORMAL);
		send(enc_r(5'd4, 5'd1, 5'd2), 32'h504, 1'b0, isa_pkg::IMEM_NORMAL);
		send(enc_r(5'd5, 5'd1, 5'd2), 32'h508, 1'b0, isa_pkg::IMEM_NORMAL);
		repeat (2) @(posedge clk);
		@(negedge clk);
		check_val("dsp_valid", dsp_valid, 1'b1);
		@(posedge clk);
		flush_req <= 1'b1;
		@(negedge clk);
		check_val("dsp_valid", dsp_valid, 1'b0);
		@(posedge clk);
		flush_req <= 1'b0;
		@(negedge clk);
		check_val("dsp_valid", dsp_valid, 1'b0);
		exp_q.delete(); // flushed ones never come out
		fork
			begin
				send(enc_u(5'd11, 20'h12345), 32'h600, 1'b0, isa_pkg::IMEM_NORMAL);
				send(enc_i(7'b0010011, 5'd12, 5'd2, 12'd7), 32'h604, 1'b0, isa_pkg::IMEM_NORMAL);
			end
			recv(2, 1'b0);
		join
		repeat (4) @(posedge clk);
		@(negedge clk);
		check_val("dsp_valid", dsp_valid, 1'b0); // nothing stale behind them
		report("flush", e0);
	endtask

	initial
	begin
		errors = 0;
		checks = 0;
		lfsr_state = 16'd89;
		resetn = 1'b0;
		flush_req = 1'b0;
		if_pc = '0;
		if_inst = '0;
		if_prdt_jump = 1'b0;
		if_imem_err = isa_pkg::IMEM_NORMAL;
		if_valid = 1'b0;
		wb_en = 1'b0;
		wb_rd_id = '0;
		wb_data = '0;
		dsp_ready = 1'b1;
		ref_regs[0] = '0;
		repeat (10) @(posedge clk);
		resetn <= 1'b1;
		@(negedge clk);
		check_val("if_ready", if_ready, 1'b0); // first cycle out of reset
		check_val("dsp_valid", dsp_valid, 1'b0);
		// known random contents everywhere
		for (int r = 1; r < 32; r++)
			write_reg(5'(r), rand_bits(32));
		test_alu();
		test_lsu();
		test_branch();
		test_errors();
		test_random();
		test_flush();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule
